// ==== Bender.yml ====
package:
  name: cart_mapper

sources:
  - include_dirs:
      - include
    files:
      - hdl/cart_types_pkg.sv
      - hdl/cart_bus_pkg.sv
      - hdl/cart_if.sv
      - hdl/bank_table.sv
      - hdl/io_access.sv
      - hdl/discharge_timer.sv
      - hdl/cart_mode_ctrl.sv
      - hdl/addr_translate.sv
      - hdl/cart_mapper.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/cart_mapper_tb.sv

// ==== cart_mapper.f ====
+incdir+include
hdl/cart_types_pkg.sv
hdl/cart_bus_pkg.sv
hdl/cart_if.sv
hdl/bank_table.sv
hdl/io_access.sv
hdl/discharge_timer.sv
hdl/cart_mode_ctrl.sv
hdl/addr_translate.sv
hdl/cart_mapper.sv
tb/cart_mapper_tb.sv

// ==== hdl/addr_translate.sv ====
`include "cart_config.svh"

module addr_translate (
	input  logic                    reset_n,
	input  logic                    roml,
	input  logic                    romh,
	input  logic                    iof,
	input  logic                    mem_write,
	input  logic [15:0]             addr_in,
	bank_map_if.map                 map,
	output logic [`CART_ADDR_W-1:0] addr_out,
	output logic                    mem_write_out
);
	import cart_bus_pkg::*;

	localparam int OFS_W = `CART_ADDR_W - `CART_PAGE_W;

	logic ultimax;
	logic cs_iof;

	assign ultimax = map.lines.exrom & ~map.lines.game;
	assign cs_iof  = iof & (mem_write ? map.iof_wr_ena : map.iof_ena);

	// ********************
	// CPU address to SDRAM
	// ********************
	always_comb begin
		// No RAM under ROML in Ultimax so the write is dropped
		mem_write_out = mem_write & ~(roml & ultimax);
		addr_out      = `CART_ADDR_W'(addr_in);

		if (!reset_n) begin
			if (romh && !mem_write)
				addr_out[`CART_ADDR_W-1:OFS_W] = rom_page(map.bank_hi);
			if (roml && !mem_write)
				addr_out = {rom_page(map.bank_lo), addr_in[OFS_W-1:0]};
			if (cs_iof)
				addr_out[`CART_ADDR_W-1:OFS_W] = ram_page(map.iof_bank);   // $DFxx RAM
		end
	end

endmodule

// ==== hdl/bank_table.sv ====
`include "cart_config.svh"

module bank_table (
	input  logic                   clk32,
	input  logic                   cart_loading,
	input  logic                   cart_bank_wr,
	input  logic [15:0]            cart_bank_num,
	input  logic [15:0]            cart_bank_laddr,
	input  logic [15:0]            cart_bank_size,
	input  logic [`CART_ADDR_W-1:0] cart_bank_raddr,
	input  cart_types_pkg::bank_t  rd_bank,
	output cart_types_pkg::bank_t  lo_entry,
	output cart_types_pkg::bank_t  hi_entry,
	output logic [7:0]             bank_cnt
);
	import cart_types_pkg::*;

	localparam int IDX_W = $clog2(`CART_TABLE_DEPTH);

	bank_t            lo_mem [`CART_TABLE_DEPTH];
	bank_t            hi_mem [`CART_TABLE_DEPTH];
	bank_t            raw_page;
	logic [IDX_W-1:0] wr_idx;
	logic             loading_q;

	assign raw_page = cart_bank_raddr[19:13];   // 8K page inside the CRT image
	assign wr_idx   = cart_bank_num[IDX_W-1:0];

	always_ff @(posedge clk32) begin
		loading_q <= cart_loading;
		if (cart_loading && !loading_q)
			bank_cnt <= '0;   // New file
		if (cart_bank_wr) begin
			bank_cnt <= bank_cnt + 8'd1;
			if (cart_bank_num < `CART_TABLE_DEPTH) begin
				if (cart_bank_laddr <= 16'h8000) begin
					lo_mem[wr_idx] <= raw_page;
					// Upper half of a 16K chip packet follows directly
					if (cart_bank_size > 16'h2000)
						hi_mem[wr_idx] <= raw_page + bank_t'(1);
				end else begin
					hi_mem[wr_idx] <= raw_page;   // Loaded at $A000 or $E000
				end
			end
		end
	end

	assign lo_entry = lo_mem[rd_bank[IDX_W-1:0]];
	assign hi_entry = hi_mem[rd_bank[IDX_W-1:0]];

endmodule

// ==== hdl/cart_bus_pkg.sv ====
`include "cart_config.svh"

package cart_bus_pkg;

	// ********************
	// Byte written to the IOE window
	// ********************
	typedef union packed {
		struct packed {
			logic [1:0] pad;
			logic [5:0] bank;       // $DE00 bank select
		} ef_bank;
		struct packed {
			logic [4:0] unused;
			logic       boot;       // Boot jumper low keeps GAME low
			logic       exrom_off;
			logic       game_off;
		} ef_ctrl;
	} io_reg_u;

	// SDRAM address bits above the 8K offset
	typedef logic [`CART_PAGE_W-1:0] page_t;

	// ROM banks live at 0x100000 with one 8K page each
	function automatic page_t rom_page(cart_types_pkg::bank_t bank);
		return page_t'({1'b1, bank});
	endfunction

	// Eight RAM banks live at 0x010000
	function automatic page_t ram_page(cart_types_pkg::bank_t bank);
		return page_t'({1'b1, bank[2:0]});
	endfunction

endpackage

// ==== hdl/cart_if.sv ====
// Current mapping state owned by the mode controller
interface bank_map_if;
	import cart_types_pkg::*;

	bank_t  bank_lo;
	bank_t  bank_hi;
	lines_t lines;
	bank_t  iof_bank;
	logic   iof_ena;      // IOF window mapped for reads
	logic   iof_wr_ena;   // IOF window mapped for writes

	modport ctrl (output bank_lo, bank_hi, lines, iof_bank, iof_ena, iof_wr_ena);
	modport map  (input  bank_lo, bank_hi, lines, iof_bank, iof_ena, iof_wr_ena);
endinterface

// One-cycle strobes on the rising edge of the I/O selects
interface io_strobe_if;
	logic ioe_wr;
	logic ioe_rd;
	logic iof_wr;
	logic ioe_stb;
	logic iof_stb;

	modport source (output ioe_wr, ioe_rd, iof_wr, ioe_stb, iof_stb);
	modport sink   (input  ioe_wr, ioe_rd, iof_wr, ioe_stb, iof_stb);
endinterface

// ==== hdl/cart_mapper.sv ====
module cart_mapper (
	input  logic        clk32,
	input  logic        reset_n,
	input  logic        cart_loading,
	input  logic [15:0] cart_id,
	input  logic [7:0]  cart_exrom,
	input  logic [7:0]  cart_game,
	input  logic [15:0] cart_bank_laddr,
	input  logic [15:0] cart_bank_size,
	input  logic [15:0] cart_bank_num,
	input  logic [24:0] cart_bank_raddr,
	input  logic        cart_bank_wr,
	input  logic        roml,
	input  logic        romh,
	input  logic        ioe,
	input  logic        iof,
	input  logic        mem_write,
	input  logic        mem_ce,
	input  logic [15:0] addr_in,
	input  logic [7:0]  data_in,
	output logic        exrom,
	output logic        game,
	output logic        mem_ce_out,
	output logic        mem_write_out,
	output logic        io_rom,
	output logic [24:0] addr_out
);
	import cart_types_pkg::*;

	bank_t rd_bank;
	bank_t lo_entry;
	bank_t hi_entry;

	bank_map_if  map_bus ();
	io_strobe_if strobe_bus ();

	assign exrom = map_bus.lines.exrom;
	assign game  = map_bus.lines.game;

	// ********************
	// Bank table from the CRT loader
	// ********************
	bank_table bank_table_i (
		.clk32           (clk32),
		.cart_loading    (cart_loading),
		.cart_bank_wr    (cart_bank_wr),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_raddr (cart_bank_raddr),
		.rd_bank         (rd_bank),
		.lo_entry        (lo_entry),
		.hi_entry        (hi_entry),
		.bank_cnt        ()   // Loader diagnostics only
	);

	io_access io_access_i (
		.clk32      (clk32),
		.ioe        (ioe),
		.iof        (iof),
		.mem_write  (mem_write),
		.mem_ce     (mem_ce),
		.strobe     (strobe_bus.source),
		.map        (map_bus.map),
		.mem_ce_out (mem_ce_out),
		.io_rom     (io_rom)
	);

	cart_mode_ctrl cart_mode_ctrl_i (
		.clk32      (clk32),
		.reset_n    (reset_n),
		.cart_id    (cart_type_e'(cart_id)),
		.cart_exrom (cart_exrom),
		.cart_game  (cart_game),
		.ioe        (ioe),
		.roml       (roml),
		.addr_in    (addr_in),
		.data_in    (data_in),
		.lo_entry   (lo_entry),
		.hi_entry   (hi_entry),
		.rd_bank    (rd_bank),
		.strobe     (strobe_bus.sink),
		.map        (map_bus.ctrl)
	);

	addr_translate addr_translate_i (
		.reset_n       (reset_n),
		.roml          (roml),
		.romh          (romh),
		.iof           (iof),
		.mem_write     (mem_write),
		.addr_in       (addr_in),
		.map           (map_bus.map),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out)
	);

endmodule

// ==== hdl/cart_mode_ctrl.sv ====
module cart_mode_ctrl (
	input  logic                       clk32,
	input  logic                       reset_n,
	input  cart_types_pkg::cart_type_e cart_id,
	input  logic [7:0]                 cart_exrom,
	input  logic [7:0]                 cart_game,
	input  logic                       ioe,
	input  logic                       roml,
	input  logic [15:0]                addr_in,
	input  cart_bus_pkg::io_reg_u      data_in,
	input  cart_types_pkg::bank_t      lo_entry,
	input  cart_types_pkg::bank_t      hi_entry,
	output cart_types_pkg::bank_t      rd_bank,
	io_strobe_if.sink                  strobe,
	bank_map_if.ctrl                   map
);
	import cart_types_pkg::*;

	typedef enum logic {
		ST_BOOT,   // Init values loaded and boot values next
		ST_RUN
	} state_e;

	state_e     state;
	cart_type_e old_id;
	logic [7:0] data_raw;
	logic       is_ef;
	logic       charge;
	logic       expired;

	assign data_raw = data_in;
	assign is_ef    = (cart_id == CT_EASYFLASH) || (cart_id == CT_EASYFLASH_X);

	// Table entry 0 unless the EasyFlash bank register selects another
	assign rd_bank = (is_ef && state == ST_RUN) ? bank_t'(data_in.ef_bank.bank) : '0;

	// Epyx capacitor charged by ROML or IOE activity
	assign charge = (state == ST_BOOT) | roml | ioe | strobe.ioe_rd;

	discharge_timer epyx_cap_i (
		.clk32   (clk32),
		.reload  (charge),
		.expired (expired)
	);

	always_ff @(posedge clk32) begin
		old_id <= cart_id;

		if (reset_n || old_id != cart_id) begin
			state          <= ST_BOOT;
			map.bank_lo    <= '0;
			map.bank_hi    <= '0;
			map.iof_bank   <= '0;
			map.iof_ena    <= 1'b0;
			map.iof_wr_ena <= 1'b0;
			map.lines      <= '{exrom: 1'b1, game: 1'b1};   // Cart invisible
		end else begin
			state <= ST_RUN;

			case (cart_id)
				// ********************
				// Generic 8K, 16K and Ultimax
				// ********************
				CT_GENERIC: begin
					map.lines.exrom <= cart_exrom[0];
					map.lines.game  <= cart_game[0];
					map.bank_lo     <= lo_entry;
					map.bank_hi     <= hi_entry;
				end

				// Ocean type 1 mirrors one bank at $8000 and $A000
				CT_OCEAN: begin
					map.lines <= '{exrom: 1'b0, game: 1'b0};
					if (state == ST_RUN && strobe.ioe_wr) begin
						map.bank_lo <= bank_t'(data_raw[5:0]);
						map.bank_hi <= bank_t'(data_raw[5:0]);
					end
				end

				// Epyx Fastload maps 8K while the capacitor holds
				CT_EPYX: begin
					if (charge)
						map.lines <= '{exrom: 1'b0, game: 1'b1};
					else if (expired)
						map.lines.exrom <= 1'b1;   // Discharged so the cart goes off
				end

				// Magic Desk 8K banks at $8000
				CT_MAGIC_DESK: begin
					if (state == ST_BOOT) begin
						map.lines   <= '{exrom: 1'b0, game: 1'b1};
						map.bank_lo <= '0;
					end else if (strobe.ioe_wr) begin
						map.bank_lo     <= bank_t'(data_raw[3:0]);
						map.lines.exrom <= data_raw[7];   // Bit 7 hides the cart
					end
				end

				// ********************
				// EasyFlash bank at $DE00 and control at $DE02
				// ********************
				CT_EASYFLASH, CT_EASYFLASH_X: begin
					if (state == ST_BOOT) begin
						map.iof_bank    <= '0;
						map.iof_ena     <= 1'b1;   // 256 bytes of RAM at $DF00
						map.iof_wr_ena  <= 1'b1;
						map.lines.exrom <= (cart_id == CT_EASYFLASH);
						map.lines.game  <= 1'b0;
						map.bank_lo     <= lo_entry;
						map.bank_hi     <= hi_entry;
					end else if (strobe.ioe_wr) begin
						if (addr_in[1]) begin
							map.lines.game  <= ~data_in.ef_ctrl.game_off & data_in.ef_ctrl.boot;
							map.lines.exrom <= ~data_in.ef_ctrl.exrom_off;
						end else begin
							map.bank_lo <= lo_entry;
							map.bank_hi <= hi_entry;
						end
					end
				end

				default: begin
					map.lines <= '{exrom: 1'b1, game: 1'b1};   // Unsupported ids stay off the bus
				end
			endcase
		end
	end

endmodule

// ==== hdl/cart_types_pkg.sv ====
`include "cart_config.svh"

package cart_types_pkg;

	// ********************
	// Cartridge ids as found in the CRT header
	// ********************
	typedef enum logic [15:0] {
		CT_GENERIC     = 16'd0,
		CT_OCEAN       = 16'd5,
		CT_EPYX        = 16'd10,
		CT_MAGIC_DESK  = 16'd19,
		CT_EASYFLASH   = 16'd32,
		CT_EASYFLASH_X = 16'd33   // XBank flavour that does not boot in Ultimax
	} cart_type_e;

	// Bank number as stored in the table
	typedef logic [`CART_BANK_W-1:0] bank_t;

	// Expansion port lines are active low on the C64 side
	typedef struct packed {
		logic exrom;
		logic game;
	} lines_t;

endpackage

// ==== hdl/discharge_timer.sv ====
`include "cart_config.svh"

module discharge_timer (
	input  logic clk32,
	input  logic reload,
	output logic expired
);

	logic [14:0] count;

	// Capacitor charged by every access and drained one step per cycle
	always_ff @(posedge clk32) begin
		if (reload)
			count <= 15'(`CART_DISCHARGE);
		else if (count != '0)
			count <= count - 15'd1;
	end

	assign expired = (count == '0);

endmodule

// ==== hdl/io_access.sv ====
module io_access (
	input  logic       clk32,
	input  logic       ioe,
	input  logic       iof,
	input  logic       mem_write,
	input  logic       mem_ce,
	io_strobe_if.source strobe,
	bank_map_if.map    map,
	output logic       mem_ce_out,
	output logic       io_rom
);

	logic ioe_q;
	logic iof_q;
	logic cs_iof;

	always_ff @(posedge clk32) begin
		ioe_q <= ioe;
		iof_q <= iof;
	end

	// ********************
	// Edge strobes
	// ********************
	assign strobe.ioe_stb = ioe & ~ioe_q;
	assign strobe.iof_stb = iof & ~iof_q;

	assign strobe.ioe_wr = strobe.ioe_stb & mem_write;
	assign strobe.ioe_rd = strobe.ioe_stb & ~mem_write;
	assign strobe.iof_wr = strobe.iof_stb & mem_write;

	// IOF goes to SDRAM only when the window is mapped for this direction
	assign cs_iof = iof & (mem_write ? map.iof_wr_ena : map.iof_ena);

	// One extra SDRAM cycle per IOF access for writes and reads alike
	assign mem_ce_out = mem_ce | (cs_iof & (strobe.iof_wr | (strobe.iof_stb & ~mem_write)));

	assign io_rom = map.iof_ena & ~mem_write;   // Relocation flag for the bus

endmodule

// ==== include/cart_config.svh ====
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// Bank numbering and lookup table
`define CART_BANK_W      7
`define CART_TABLE_DEPTH 64

// 8K SDRAM pages above a 13-bit offset
`define CART_ADDR_W      25
`define CART_PAGE_W      12

// Epyx capacitor discharge time in clk32 cycles
`define CART_DISCHARGE   16384

`endif

// ==== tb/cart_mapper_tb.sv ====
`include "cart_config.svh"

module cart_mapper_tb;

	localparam int TIMEOUT_CYCLES = 2 * `CART_DISCHARGE + 2000;
	localparam int IDLE_GAP       = `CART_DISCHARGE / 4 + 64;   // Four gaps outlast one discharge

	logic        clk32;
	logic        reset_n;
	logic        cart_loading;
	logic [15:0] cart_id;
	logic [7:0]  cart_exrom;
	logic [7:0]  cart_game;
	logic [15:0] cart_bank_laddr;
	logic [15:0] cart_bank_size;
	logic [15:0] cart_bank_num;
	logic [24:0] cart_bank_raddr;
	logic        cart_bank_wr;
	logic        roml;
	logic        romh;
	logic        ioe;
	logic        iof;
	logic        mem_write;
	logic        mem_ce;
	logic [15:0] addr_in;
	logic [7:0]  data_in;
	logic        exrom;
	logic        game;
	logic        mem_ce_out;
	logic        mem_write_out;
	logic        io_rom;
	logic [24:0] addr_out;

	integer     seed = 32'h8fbc91d8;
	int         cycle_cnt = 0;
	logic [6:0] lo_exp [2];   // Low entries as the loader should store them

	cart_mapper dut_i (.*);

	initial begin
		clk32 = 1'b0;
		forever #4 clk32 = ~clk32;
	end

	always @(posedge clk32) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout, tests still running after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	task automatic check_eq(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s expected %0h actual %0h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// ROM bank n sits at 0x100000 + n * 0x2000
	function automatic logic [24:0] expected_rom_addr(input logic [6:0] bank,
			input logic [15:0] addr);
		return 25'h100000 + 25'(bank) * 25'h2000 + 25'(addr[12:0]);
	endfunction

	// ********************
	// Bus helpers
	// ********************
	task automatic load_bank(input logic [15:0] num, input logic [15:0] laddr,
			input logic [15:0] size, input logic [24:0] raddr);
		@(negedge clk32);
		cart_bank_wr    = 1'b1;
		cart_bank_num   = num;
		cart_bank_laddr = laddr;
		cart_bank_size  = size;
		cart_bank_raddr = raddr;
		@(negedge clk32);
		cart_bank_wr = 1'b0;
	endtask

	// Boot values land two edges after the id change
	task automatic select_cart(input logic [15:0] id, input logic [7:0] ex, input logic [7:0] gm);
		@(negedge clk32);
		cart_id    = id;
		cart_exrom = ex;
		cart_game  = gm;
		repeat (2) @(negedge clk32);
	endtask

	task automatic io_cycle(input logic write, input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk32);
		ioe       = 1'b1;
		mem_write = write;
		addr_in   = addr;
		data_in   = data;
		@(negedge clk32);   // Register updated on this edge
		ioe       = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic check_rom_read(input string name, input logic high, input logic [15:0] addr,
			input logic [24:0] expected);
		@(negedge clk32);
		roml      = ~high;
		romh      = high;
		mem_write = 1'b0;
		addr_in   = addr;
		#2;
		check_eq(name, expected, addr_out);
		@(negedge clk32);
		roml = 1'b0;
		romh = 1'b0;
	endtask

	// ********************
	// Directed tests
	// ********************
	task automatic test_reset_values();
		@(negedge clk32);
		mem_ce  = 1'b1;
		roml    = 1'b1;
		addr_in = 16'h8123;
		#2;
		check_eq("reset exrom", 1, exrom);
		check_eq("reset game", 1, game);
		check_eq("reset mem_ce_out", 1, mem_ce_out);
		check_eq("reset io_rom", 0, io_rom);
		check_eq("reset addr_out", 32'h8123, addr_out);   // No translation yet
	endtask

	task automatic test_generic();
		logic [24:0] raddr;
		int          i;
		@(negedge clk32);
		cart_loading = 1'b1;
		for (i = 0; i < 2; i++) begin
			raddr     = 25'($random(seed));
			lo_exp[i] = raddr[19:13];
			load_bank(16'(i), 16'h8000, 16'h4000, raddr);   // 16K chip packets
		end
		@(negedge clk32);
		cart_loading = 1'b0;
		select_cart(16'd0, 8'h00, 8'h01);
		check_eq("generic exrom", 0, exrom);
		check_eq("generic game", 1, game);
		check_rom_read("generic roml", 1'b0, 16'h8123, expected_rom_addr(lo_exp[0], 16'h8123));
		check_rom_read("generic romh", 1'b1, 16'hA123,
			expected_rom_addr(lo_exp[0] + 7'd1, 16'hA123));
	endtask

	task automatic test_ocean();
		select_cart(16'd5, 8'h00, 8'h00);
		check_eq("ocean game", 0, game);
		io_cycle(1'b1, 16'hDE00, 8'h2A);
		check_rom_read("ocean roml", 1'b0, 16'h8456, expected_rom_addr(7'h2A, 16'h8456));
		check_rom_read("ocean romh", 1'b1, 16'hA789, expected_rom_addr(7'h2A, 16'hA789));
	endtask

	task automatic test_magic_desk();
		select_cart(16'd19, 8'h00, 8'h00);
		check_eq("magic desk exrom", 0, exrom);
		check_eq("magic desk game", 1, game);
		io_cycle(1'b1, 16'hDE00, 8'h05);
		check_rom_read("magic desk roml", 1'b0, 16'h9ABC, expected_rom_addr(7'd5, 16'h9ABC));
		io_cycle(1'b1, 16'hDE00, 8'h85);
		check_eq("magic desk hide", 1, exrom);
	endtask

	task automatic test_easyflash();
		select_cart(16'd33, 8'h00, 8'h00);
		check_eq("easyflash boot exrom", 0, exrom);
		check_eq("easyflash boot game", 0, game);
		check_eq("easyflash io_rom", 1, io_rom);   // IOF RAM mapped for reads
		io_cycle(1'b1, 16'hDE00, 8'h01);
		check_rom_read("easyflash roml", 1'b0, 16'h8010, expected_rom_addr(lo_exp[1], 16'h8010));
		io_cycle(1'b1, 16'hDE02, 8'h04);
		check_eq("easyflash ctrl game", 1, game);
		check_eq("easyflash ctrl exrom", 1, exrom);

		// RAM write at $DF42 in the first IOF cycle
		@(negedge clk32);
		iof       = 1'b1;
		mem_write = 1'b1;
		mem_ce    = 1'b0;
		addr_in   = 16'hDF42;
		#2;
		check_eq("easyflash iof addr", 25'h010000 + 25'h1F42, addr_out);
		check_eq("easyflash iof ce", 1, mem_ce_out);
		check_eq("easyflash iof we", 1, mem_write_out);
		@(negedge clk32);
		#2;
		check_eq("easyflash iof ce pulse", 0, mem_ce_out);   // IOF still high
		@(negedge clk32);
		iof       = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic test_ultimax();
		select_cart(16'd32, 8'h00, 8'h00);
		check_eq("ultimax exrom", 1, exrom);
		check_eq("ultimax game", 0, game);
		@(negedge clk32);
		roml      = 1'b1;
		mem_write = 1'b1;
		addr_in   = 16'h8000;
		#2;
		check_eq("ultimax roml write", 0, mem_write_out);
		@(negedge clk32);
		roml = 1'b0;
		#2;
		check_eq("ultimax plain write", 1, mem_write_out);
		@(negedge clk32);
		mem_write = 1'b0;
	endtask

	task automatic test_epyx();
		int i;
		select_cart(16'd10, 8'h00, 8'h00);
		check_eq("epyx boot exrom", 0, exrom);
		check_eq("epyx boot game", 1, game);
		for (i = 0; i < 4; i++) begin
			io_cycle(1'b0, 16'hDE00, 8'h00);
			repeat (IDLE_GAP) @(negedge clk32);
			check_eq("epyx charged", 0, exrom);
		end
		io_cycle(1'b0, 16'hDE00, 8'h00);
		repeat (`CART_DISCHARGE - 4) @(negedge clk32);
		check_eq("epyx near empty", 0, exrom);
		repeat (8) @(negedge clk32);
		check_eq("epyx discharged", 1, exrom);
		io_cycle(1'b0, 16'hDE00, 8'h00);
		check_eq("epyx recharge", 0, exrom);
	endtask

	initial begin
		reset_n         = 1'b1;
		cart_loading    = 1'b0;
		cart_id         = 16'd0;
		cart_exrom      = 8'h01;
		cart_game       = 8'h01;
		cart_bank_laddr = 16'h0000;
		cart_bank_size  = 16'h0000;
		cart_bank_num   = 16'h0000;
		cart_bank_raddr = 25'h0;
		cart_bank_wr    = 1'b0;
		roml            = 1'b0;
		romh            = 1'b0;
		ioe             = 1'b0;
		iof             = 1'b0;
		mem_write       = 1'b0;
		mem_ce          = 1'b0;
		addr_in         = 16'h0000;
		data_in         = 8'h00;

		repeat (14) @(negedge clk32);
		test_reset_values();
		@(negedge clk32);
		mem_ce  = 1'b0;
		roml    = 1'b0;
		reset_n = 1'b0;   // Leave reset after 16 cycles

		test_generic();
		test_ocean();
		test_magic_desk();
		test_easyflash();
		test_ultimax();
		test_epyx();

		$display("TEST OK");
		$finish;
	end

endmodule
